// File: dino_pkg.sv
/*
 * Shared game definitions
 *  - vector types for positions, heights, score and random bytes
 *  - game state and obstacle type enums
 *  - fixed hitbox geometry and jump constant
 *  - helper that tells whether the game is in a running state
 */

package dino_pkg;

    typedef logic [7:0]  xpos_t;    // Coarse horizontal units
    typedef logic [4:0]  height_t;  // Above ground
    typedef logic [19:0] score_t;   // Five BCD digits
    typedef logic [7:0]  rng_t;

    typedef enum logic [2:0] {
        GS_IDLE,
        GS_RUN,
        GS_JUMP,
        GS_DUCK,
        GS_OVER
    } game_state_t;

    typedef enum logic [1:0] {
        OBS_SMALL,
        OBS_TALL,
        OBS_BIRD
    } obs_type_t;

    // Player column
    localparam int PLAYER_X = 16;
    localparam int PLAYER_W = 6;
    localparam int OBS_W    = 4;
    localparam int JUMP_V0  = 6;   // Initial upward velocity

    // Vertical bands
    localparam int SMALL_H  = 4;
    localparam int TALL_H   = 7;
    localparam int BIRD_LO  = 3;
    localparam int BIRD_TOP = 9;
    localparam int STAND_H  = 10;
    localparam int DUCK_H   = 2;

    function automatic logic is_running(input game_state_t st);
        return (st == GS_RUN) || (st == GS_JUMP) || (st == GS_DUCK);
    endfunction

endpackage

// File: tick_gen.sv
/*
 * Frame tick generator
 * Down-counter that reloads at zero and strobes the tick
 * for one cycle every TICK_DIV clock cycles
 */

`timescale 1ns/1ps

module tick_gen #(
    parameter int TICK_DIV = 16
) (
    input  logic clk,
    input  logic i_rst_n,
    output logic o_tick
);

    localparam int CW = $clog2(TICK_DIV);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else begin
            if (cnt == '0)
                cnt <= CW'(TICK_DIV - 1);  // Reload
            else
                cnt <= cnt - 1'b1;
            o_tick <= (cnt == CW'(1));     // High while the counter sits at zero
        end
    end

endmodule

// File: lfsr.sv
/*
 * Random source for obstacle types
 * 15-bit maximal-length Galois LFSR, x^15 + x^14 + 1,
 * stepping every clock; low byte is the output
 */

`timescale 1ns/1ps

module lfsr (
    input  logic            clk,
    input  logic            i_rst_n,
    output dino_pkg::rng_t  o_rng
);

    localparam logic [14:0] TAPS = 15'h6000;
    localparam logic [14:0] SEED = 15'h0001;  // Any nonzero value

    logic [14:0] state;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            state <= SEED;
        else
            state <= {1'b0, state[14:1]} ^ (state[0] ? TAPS : 15'h0000);
    end

    assign o_rng = state[7:0];

endmodule

// File: player_controller.sv
/*
 * Player controller
 *  - game FSM: idle, run, jump, duck, game over
 *  - jump arc from a signed velocity register
 *  - one-cycle start pulse on entry to run from idle or game over
 * All updates happen on the tick edge
 */

`timescale 1ns/1ps

module player_controller (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_tick,
    input  logic                  i_btn_start,
    input  logic                  i_btn_up,
    input  logic                  i_btn_down,
    input  logic                  i_crash,
    output dino_pkg::game_state_t o_state,
    output dino_pkg::height_t     o_height,
    output logic                  o_start_pulse
);

    logic signed [5:0] vel;
    logic signed [6:0] h_sum;

    // Height after this tick's velocity step
    assign h_sum = $signed({2'b00, o_height}) + {vel[5], vel};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state       <= dino_pkg::GS_IDLE;
            o_height      <= '0;
            vel           <= '0;
            o_start_pulse <= 1'b0;
        end else begin
            o_start_pulse <= 1'b0;
            if (i_tick) begin
                case (o_state)
                    dino_pkg::GS_IDLE, dino_pkg::GS_OVER: begin
                        if (i_btn_start) begin
                            o_state       <= dino_pkg::GS_RUN;
                            o_height      <= '0;
                            vel           <= '0;
                            o_start_pulse <= 1'b1;
                        end
                    end
                    dino_pkg::GS_RUN: begin
                        if (i_crash) begin
                            o_state <= dino_pkg::GS_OVER;
                        end else if (i_btn_up) begin   // Up wins over down
                            o_state  <= dino_pkg::GS_JUMP;
                            o_height <= dino_pkg::height_t'(dino_pkg::JUMP_V0);
                            vel      <= 6'(dino_pkg::JUMP_V0 - 1);
                        end else if (i_btn_down) begin
                            o_state <= dino_pkg::GS_DUCK;
                        end
                    end
                    dino_pkg::GS_JUMP: begin
                        if (i_crash) begin
                            o_state  <= dino_pkg::GS_OVER;
                            o_height <= '0;
                        end else if (h_sum <= 7'sd0) begin  // Landed
                            o_state  <= dino_pkg::GS_RUN;
                            o_height <= '0;
                        end else begin
                            o_height <= h_sum[4:0];
                            vel      <= vel - 6'sd1;
                        end
                    end
                    dino_pkg::GS_DUCK: begin
                        if (i_crash)
                            o_state <= dino_pkg::GS_OVER;
                        else if (!i_btn_down)
                            o_state <= dino_pkg::GS_RUN;
                    end
                    default: o_state <= dino_pkg::GS_IDLE;
                endcase
            end
        end
    end

endmodule

// File: obstacles.sv
/*
 * Obstacle engine
 *  - two obstacles scrolling left in lockstep while the game runs
 *  - spawn on game start, respawn when past the left edge
 *  - types drawn from the random byte, code 3 folds to small cactus
 */

`timescale 1ns/1ps

module obstacles #(
    parameter int SPAWN_X  = 200,
    parameter int OBS_GAP  = 100,
    parameter int OBS_STEP = 2
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_tick,
    input  dino_pkg::game_state_t i_state,
    input  logic                  i_start_pulse,
    input  dino_pkg::rng_t        i_rng,
    output dino_pkg::xpos_t       o_obs1_x,
    output dino_pkg::xpos_t       o_obs2_x,
    output dino_pkg::obs_type_t   o_obs1_type,
    output dino_pkg::obs_type_t   o_obs2_type
);

    dino_pkg::xpos_t     pos  [2];
    dino_pkg::obs_type_t kind [2];
    logic [1:0]          code [2];

    function automatic dino_pkg::obs_type_t pick_type(input logic [1:0] c);
        case (c)
            2'd1:    return dino_pkg::OBS_TALL;
            2'd2:    return dino_pkg::OBS_BIRD;
            default: return dino_pkg::OBS_SMALL;
        endcase
    endfunction

    assign code[0] = i_rng[1:0];   // Obstacle 1 from low bits
    assign code[1] = i_rng[7:6];   // Obstacle 2 from high bits

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2; i++) begin
                pos[i]  <= '0;
                kind[i] <= dino_pkg::OBS_SMALL;
            end
        end else if (i_start_pulse) begin
            pos[0] <= dino_pkg::xpos_t'(SPAWN_X);
            pos[1] <= dino_pkg::xpos_t'(SPAWN_X + OBS_GAP);  // Wraps in the 8-bit column
            for (int i = 0; i < 2; i++) begin
                kind[i] <= pick_type(code[i]);
            end
        end else if (i_tick && dino_pkg::is_running(i_state)) begin
            for (int i = 0; i < 2; i++) begin
                if (pos[i] < dino_pkg::xpos_t'(OBS_STEP)) begin  // Off screen
                    pos[i]  <= dino_pkg::xpos_t'(SPAWN_X);
                    kind[i] <= pick_type(code[i]);
                end else begin
                    pos[i] <= pos[i] - dino_pkg::xpos_t'(OBS_STEP);
                end
            end
        end
    end

    assign o_obs1_x    = pos[0];
    assign o_obs2_x    = pos[1];
    assign o_obs1_type = kind[0];
    assign o_obs2_type = kind[1];

endmodule

// File: collision_detect.sv
/*
 * Collision unit
 * Hitbox overlap of the player against each obstacle
 * on half-open bands, with the result registered one cycle later
 */

`timescale 1ns/1ps

module collision_detect (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  dino_pkg::game_state_t i_state,
    input  dino_pkg::height_t     i_height,
    input  dino_pkg::xpos_t       i_obs1_x,
    input  dino_pkg::xpos_t       i_obs2_x,
    input  dino_pkg::obs_type_t   i_obs1_type,
    input  dino_pkg::obs_type_t   i_obs2_type,
    output logic                  o_crash
);

    logic duck;
    logic hit1;
    logic hit2;

    function automatic logic hit(input dino_pkg::xpos_t x, input dino_pkg::obs_type_t t,
                                 input dino_pkg::height_t h, input logic ducking);
        int x_lo;
        int p_lo;
        int p_hi;
        int b_lo;
        int b_hi;
        x_lo = int'(x);
        p_lo = int'(h);
        p_hi = p_lo + (ducking ? dino_pkg::DUCK_H : dino_pkg::STAND_H);
        case (t)
            dino_pkg::OBS_TALL: begin
                b_lo = 0;
                b_hi = dino_pkg::TALL_H;
            end
            dino_pkg::OBS_BIRD: begin
                b_lo = dino_pkg::BIRD_LO;
                b_hi = dino_pkg::BIRD_TOP;
            end
            default: begin
                b_lo = 0;
                b_hi = dino_pkg::SMALL_H;
            end
        endcase
        return (x_lo < dino_pkg::PLAYER_X + dino_pkg::PLAYER_W) &&
               (x_lo + dino_pkg::OBS_W > dino_pkg::PLAYER_X) &&
               (p_lo < b_hi) && (p_hi > b_lo);
    endfunction

    assign duck = (i_state == dino_pkg::GS_DUCK);
    assign hit1 = hit(i_obs1_x, i_obs1_type, i_height, duck);
    assign hit2 = hit(i_obs2_x, i_obs2_type, i_height, duck);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_crash <= 1'b0;
        else
            o_crash <= hit1 | hit2;
    end

endmodule

// File: score_counter.sv
/*
 * Score counter
 * Five BCD digits with ripple carry, one count per running tick,
 * cleared by the start pulse, wraps at 99999
 */

`timescale 1ns/1ps

module score_counter (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_tick,
    input  dino_pkg::game_state_t i_state,
    input  logic                  i_start_pulse,
    output dino_pkg::score_t      o_score
);

    dino_pkg::score_t score_inc;
    logic             carry;

    // BCD increment, digit 0 first
    always_comb begin
        carry     = 1'b1;
        score_inc = o_score;
        for (int d = 0; d < 5; d++) begin
            if (carry) begin
                if (o_score[4*d +: 4] == 4'd9) begin
                    score_inc[4*d +: 4] = 4'd0;   // Carry on to next digit
                end else begin
                    score_inc[4*d +: 4] = o_score[4*d +: 4] + 4'd1;
                    carry               = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_score <= '0;
        else if (i_start_pulse)
            o_score <= '0;
        else if (i_tick && dino_pkg::is_running(i_state))
            o_score <= score_inc;
    end

endmodule

// File: dino_game_top.sv
/*
 * Runner game core top level
 * Tick generator, LFSR, player FSM, obstacle engine,
 * collision unit and score counter wired together
 */

`timescale 1ns/1ps

module dino_game_top #(
    parameter int TICK_DIV = 16,   // Short frame for simulation
    parameter int SPAWN_X  = 200,
    parameter int OBS_GAP  = 100,
    parameter int OBS_STEP = 2
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_btn_start,
    input  logic                  i_btn_up,
    input  logic                  i_btn_down,
    output logic                  o_tick,
    output dino_pkg::game_state_t o_game_state,
    output dino_pkg::height_t     o_height,
    output dino_pkg::xpos_t       o_obs1_x,
    output dino_pkg::xpos_t       o_obs2_x,
    output dino_pkg::obs_type_t   o_obs1_type,
    output dino_pkg::obs_type_t   o_obs2_type,
    output dino_pkg::score_t      o_score
);

    logic           start_pulse;
    logic           crash;    // From collision unit back to the FSM
    dino_pkg::rng_t rng;

    tick_gen #(.TICK_DIV(TICK_DIV)) tick_gen_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_tick  (o_tick)
    );

    lfsr lfsr_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .o_rng   (rng)
    );

    player_controller player_controller_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_tick        (o_tick),
        .i_btn_start   (i_btn_start),
        .i_btn_up      (i_btn_up),
        .i_btn_down    (i_btn_down),
        .i_crash       (crash),
        .o_state       (o_game_state),
        .o_height      (o_height),
        .o_start_pulse (start_pulse)
    );

    obstacles #(
        .SPAWN_X  (SPAWN_X),
        .OBS_GAP  (OBS_GAP),
        .OBS_STEP (OBS_STEP)
    ) obstacles_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_tick        (o_tick),
        .i_state       (o_game_state),
        .i_start_pulse (start_pulse),
        .i_rng         (rng),
        .o_obs1_x      (o_obs1_x),
        .o_obs2_x      (o_obs2_x),
        .o_obs1_type   (o_obs1_type),
        .o_obs2_type   (o_obs2_type)
    );

    collision_detect collision_detect_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_state     (o_game_state),
        .i_height    (o_height),
        .i_obs1_x    (o_obs1_x),
        .i_obs2_x    (o_obs2_x),
        .i_obs1_type (o_obs1_type),
        .i_obs2_type (o_obs2_type),
        .o_crash     (crash)
    );

    score_counter score_counter_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_tick        (o_tick),
        .i_state       (o_game_state),
        .i_start_pulse (start_pulse),
        .o_score       (o_score)
    );

endmodule

// File: dino_game_checker.sv
/*
 * Assertion checker bound to the game top level
 *  - frame tick lasts one cycle
 *  - player stays on the ground outside a jump
 *  - score frozen in game over, legal obstacle type codes
 */

`timescale 1ns/1ps

module dino_game_checker (
    input logic                  clk,
    input logic                  i_rst_n,
    input logic                  i_tick,
    input dino_pkg::game_state_t i_state,
    input dino_pkg::height_t     i_height,
    input dino_pkg::score_t      i_score,
    input dino_pkg::obs_type_t   i_obs1_type,
    input dino_pkg::obs_type_t   i_obs2_type
);

    tick_single: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_tick |=> !i_tick)
        else $error("frame tick high on two consecutive cycles");

    ground_height: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_state != dino_pkg::GS_JUMP) |-> (i_height == '0))
        else $error("nonzero height outside a jump");

    score_frozen: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_state == dino_pkg::GS_OVER) |=> $stable(i_score))
        else $error("score changed during game over");

    // Code 3 has no obstacle type
    type_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_obs1_type != 2'b11) && (i_obs2_type != 2'b11))
        else $error("illegal obstacle type code");

endmodule

// File: tb_dino_game.sv
/*
 * Testbench for the runner game core
 *  - reads scenarios from the case file and drives the buttons
 *  - tick-level reference model of state, height, score and obstacles
 *  - binds the assertion checker to the top level
 */

`timescale 1ns/1ps

module tb_dino_game;

    localparam int TICK_DIV  = 16;
    localparam int SPAWN_X   = 200;
    localparam int OBS_GAP   = 100;
    localparam int OBS_STEP  = 2;
    localparam int TICK_WAIT = 4 * TICK_DIV;   // Cycles allowed per frame tick

    logic                  clk;
    logic                  rst_n;
    logic                  btn_start;
    logic                  btn_up;
    logic                  btn_down;
    logic                  tick;
    dino_pkg::game_state_t game_state;
    dino_pkg::height_t     height;
    dino_pkg::xpos_t       obs1_x;
    dino_pkg::xpos_t       obs2_x;
    dino_pkg::obs_type_t   obs1_type;
    dino_pkg::obs_type_t   obs2_type;
    dino_pkg::score_t      score;

    // Reference model
    dino_pkg::game_state_t m_state;
    dino_pkg::obs_type_t   m_type [2];
    int                    m_height;
    int                    m_vel;
    int                    m_count;     // Binary frame count
    int                    m_x [2];
    int                    tick_gap;

    dino_game_top #(
        .TICK_DIV (TICK_DIV),
        .SPAWN_X  (SPAWN_X),
        .OBS_GAP  (OBS_GAP),
        .OBS_STEP (OBS_STEP)
    ) DUT (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_btn_start  (btn_start),
        .i_btn_up     (btn_up),
        .i_btn_down   (btn_down),
        .o_tick       (tick),
        .o_game_state (game_state),
        .o_height     (height),
        .o_obs1_x     (obs1_x),
        .o_obs2_x     (obs2_x),
        .o_obs1_type  (obs1_type),
        .o_obs2_type  (obs2_type),
        .o_score      (score)
    );

    bind dino_game_top dino_game_checker checker_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (o_tick),
        .i_state     (o_game_state),
        .i_height    (o_height),
        .i_score     (o_score),
        .i_obs1_type (o_obs1_type),
        .i_obs2_type (o_obs2_type)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string what, input int got, input int expected);
        $display("error: time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        stop_with_failure();
    endtask

    task automatic give_up(input string msg);
        $display("%s (time %0t)", msg, $time);
        stop_with_failure();
    endtask

    function automatic logic [19:0] to_bcd(input int value);
        logic [19:0] bcd;
        int          rest;
        rest = value;
        for (int d = 0; d < 5; d++) begin
            bcd[4*d +: 4] = 4'(rest % 10);
            rest          = rest / 10;
        end
        return bcd;
    endfunction

    function automatic bit overlaps(input int a_lo, input int a_hi, input int b_lo, input int b_hi);
        return (a_lo < b_hi) && (b_lo < a_hi);   // Half-open spans
    endfunction

    // Player hitbox against one obstacle at the model's current values
    function automatic bit predict_hit(input int x, input dino_pkg::obs_type_t t);
        int body;
        int bottom;
        int top;
        body   = (m_state == dino_pkg::GS_DUCK) ? dino_pkg::DUCK_H : dino_pkg::STAND_H;
        bottom = (t == dino_pkg::OBS_BIRD) ? dino_pkg::BIRD_LO : 0;
        if (t == dino_pkg::OBS_BIRD)
            top = dino_pkg::BIRD_TOP;
        else if (t == dino_pkg::OBS_TALL)
            top = dino_pkg::TALL_H;
        else
            top = dino_pkg::SMALL_H;
        return overlaps(x, x + dino_pkg::OBS_W,
                        dino_pkg::PLAYER_X, dino_pkg::PLAYER_X + dino_pkg::PLAYER_W) &&
               overlaps(m_height, m_height + body, bottom, top);
    endfunction

    // One frame of the game rules with crash from the pre-tick values
    task automatic model_tick(input logic [2:0] mask, output logic [1:0] spawned);
        bit crash;
        bit running;
        crash   = predict_hit(m_x[0], m_type[0]) || predict_hit(m_x[1], m_type[1]);
        running = (m_state == dino_pkg::GS_RUN) || (m_state == dino_pkg::GS_JUMP) ||
                  (m_state == dino_pkg::GS_DUCK);
        spawned = 2'b00;
        if (running) begin
            m_count = (m_count + 1) % 100000;
            for (int i = 0; i < 2; i++) begin
                if (m_x[i] < OBS_STEP) begin
                    m_x[i]     = SPAWN_X;
                    spawned[i] = 1'b1;
                end else begin
                    m_x[i] = m_x[i] - OBS_STEP;
                end
            end
        end
        case (m_state)
            dino_pkg::GS_IDLE, dino_pkg::GS_OVER: begin
                if (mask[0]) begin
                    m_state  = dino_pkg::GS_RUN;
                    m_height = 0;
                    m_count  = 0;
                    m_x[0]   = SPAWN_X % 256;
                    m_x[1]   = (SPAWN_X + OBS_GAP) % 256;   // 8-bit column wraps
                    spawned  = 2'b11;
                end
            end
            dino_pkg::GS_RUN: begin
                if (crash) begin
                    m_state = dino_pkg::GS_OVER;
                end else if (mask[1]) begin
                    m_state  = dino_pkg::GS_JUMP;
                    m_height = dino_pkg::JUMP_V0;
                    m_vel    = dino_pkg::JUMP_V0 - 1;
                end else if (mask[2]) begin
                    m_state = dino_pkg::GS_DUCK;
                end
            end
            dino_pkg::GS_JUMP: begin
                if (crash) begin
                    m_state  = dino_pkg::GS_OVER;
                    m_height = 0;
                end else if (m_height + m_vel <= 0) begin
                    m_state  = dino_pkg::GS_RUN;
                    m_height = 0;
                end else begin
                    m_height = m_height + m_vel;
                    m_vel    = m_vel - 1;
                end
            end
            default: begin
                if (crash)
                    m_state = dino_pkg::GS_OVER;
                else if (!mask[2])
                    m_state = dino_pkg::GS_RUN;
            end
        endcase
    endtask

    task automatic check_outputs(input logic [1:0] spawned);
        if (spawned[0])
            m_type[0] = obs1_type;   // New type comes from the LFSR
        if (spawned[1])
            m_type[1] = obs2_type;
        assert (game_state == m_state) else value_error("game state", game_state, m_state);
        assert (height == dino_pkg::height_t'(m_height))
            else value_error("height", height, m_height);
        assert (score == to_bcd(m_count)) else value_error("score", score, to_bcd(m_count));
        assert (obs1_x == dino_pkg::xpos_t'(m_x[0]))
            else value_error("obstacle 1 x", obs1_x, m_x[0]);
        assert (obs2_x == dino_pkg::xpos_t'(m_x[1]))
            else value_error("obstacle 2 x", obs2_x, m_x[1]);
        assert (obs1_type == m_type[0]) else value_error("obstacle 1 type", obs1_type, m_type[0]);
        assert (obs2_type == m_type[1]) else value_error("obstacle 2 type", obs2_type, m_type[1]);
    endtask

    // Frame tick period check from reset release on
    always @(negedge clk) begin
        if (rst_n) begin
            if (tick) begin
                assert (tick_gap == TICK_DIV)
                    else value_error("frame tick spacing", tick_gap, TICK_DIV);
                tick_gap = 1;
            end else begin
                tick_gap++;
            end
        end
    end

    // Drive the buttons, wait for the frame tick, then compare after the start pulse
    task automatic run_tick(input logic [2:0] mask);
        logic [1:0] spawned;
        int         waited;
        @(posedge clk);
        #1;
        btn_start = mask[0];
        btn_up    = mask[1];
        btn_down  = mask[2];
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TICK_WAIT)
                give_up("no frame tick arrived within the expected number of cycles");
        end while (!tick);
        model_tick(mask, spawned);
        @(posedge clk);
        repeat (2) @(negedge clk);   // Obstacles load one cycle after the start pulse
        check_outputs(spawned);
    endtask

    task automatic run_case(input string op, input int count, input logic [2:0] mask);
        int used;
        if (op == "start" || op == "restart") begin
            assert (m_state == ((op == "start") ? dino_pkg::GS_IDLE : dino_pkg::GS_OVER))
                else give_up({op, " case found the game in the wrong state"});
            run_tick(mask);
            assert (game_state == dino_pkg::GS_RUN)
                else value_error("state after start", game_state, dino_pkg::GS_RUN);
        end else if (op == "run") begin
            repeat (count) run_tick(mask);
        end else if (op == "jump") begin
            run_tick(mask);              // Press tick only
            repeat (count - 1) run_tick(3'b000);
            assert (game_state == dino_pkg::GS_RUN)
                else value_error("state after landing", game_state, dino_pkg::GS_RUN);
        end else if (op == "duck") begin
            repeat (count) run_tick(mask);
            assert (game_state == dino_pkg::GS_DUCK)
                else value_error("state while ducking", game_state, dino_pkg::GS_DUCK);
            run_tick(3'b000);
            assert (game_state == dino_pkg::GS_RUN)
                else value_error("state after release", game_state, dino_pkg::GS_RUN);
        end else if (op == "crash_run") begin
            used = 0;
            while (game_state != dino_pkg::GS_OVER) begin
                if (used == count)
                    give_up("the game did not reach game over within the allowed ticks");
                run_tick(mask);
                used++;
            end
        end else begin
            give_up({"unknown operation in the case file: ", op});
        end
    endtask

    initial begin
        int    fd;
        int    count;
        int    mask;
        int    n_items;
        string line;
        string op;
        tick_gap  = 0;
        btn_start = 1'b0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        rst_n     = 1'b0;
        m_state   = dino_pkg::GS_IDLE;
        m_height  = 0;
        m_vel     = 0;
        m_count   = 0;
        m_x[0]    = 0;
        m_x[1]    = 0;
        m_type[0] = dino_pkg::OBS_SMALL;
        m_type[1] = dino_pkg::OBS_SMALL;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!tick) else value_error("tick after reset", tick, 0);
        check_outputs(2'b00);
        fd = $fopen("dino_cases.txt", "r");
        if (fd == 0)
            give_up("could not open the case file dino_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin   // Skip comments and blanks
                n_items = $sscanf(line, "%s %d %d", op, count, mask);
                if (n_items != 3)
                    give_up({"malformed line in the case file: ", line});
                run_case(op, count, mask[2:0]);
            end
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dino_cases.txt
# op ticks mask, mask bits: 1 start, 2 up, 4 down
# jump presses up on its first tick only, duck holds down for the ticks then releases
run 3 0
start 1 1
run 7 0
jump 13 2
duck 5 4
run 20 0
crash_run 80 0
run 5 0
restart 1 1
run 4 0
jump 13 2
duck 3 4
crash_run 100 0
run 3 0

// File: filelist.f
dino_pkg.sv
tick_gen.sv
lfsr.sv
player_controller.sv
obstacles.sv
collision_detect.sv
score_counter.sv
dino_game_top.sv
dino_game_checker.sv
tb_dino_game.sv

// File: Makefile
# Verilator build and run of the runner game core testbench

VERILATOR  ?= verilator
TOP        ?= tb_dino_game
RTL_TOP    ?= dino_game_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= dino_pkg.sv tick_gen.sv lfsr.sv player_controller.sv obstacles.sv \
              collision_detect.sv score_counter.sv dino_game_top.sv
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
